//--- tb/mmu_vectors.txt
# op sel addr data expected exc, all hex; exc 0 none 1 tlbl 2 tlbs 3 tlbm 4 bus
# T rows: sel is the tlb index, addr the virtual page, data the physical page, expected bit0 v bit1 d
S f a0000010 01010101 00000000 0
S f a0000100 11223344 00000000 0
L f 80000100 00000000 11223344 0
S f a0000104 aabbccdd 00000000 0
S 3 a0000104 55667788 00000000 0
L f 80000104 00000000 aabb7788 0
F f 80000104 00000000 aabb7788 0
S f a0000108 cafef00d 00000000 0
B f 80000108 00000000 cafef00d 0
S f a0000200 0badc0de 00000000 0
T 0 00400000 00000000 00000003 0
L f 00400200 00000000 0badc0de 0
L f 00500000 00000000 00000000 1
S f 00500010 12345678 00000000 2
T 1 00600000 00000000 00000001 0
S f 00600100 deadbeef 00000000 3
L f 80000100 00000000 11223344 0
L f 00600100 00000000 11223344 0
T 2 00500000 00000000 00000003 0
L f 00500010 00000000 01010101 0
L f a0001000 00000000 00000000 4

//--- tb.f
+incdir+include
design/mmu_pkg.sv
design/addr_xlate.sv
design/mem_port_arbiter.sv
design/axil_master.sv
design/axil_ram.sv
design/mmu_top.sv
tb/mmu_chk.sv
tb/mmu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mmu_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -F -x '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/mmu_tb_consts.svh
`ifndef MMU_TB_CONSTS_SVH
`define MMU_TB_CONSTS_SVH

// testbench sizing
`define MMU_TB_MAX_VEC    64
`define MMU_TB_FILL_WORDS 4
`define MMU_TB_CYC_PER_OP 40

`endif

//--- tb/mmu_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "mmu_consts.svh"
`include "mmu_tb_consts.svh"

module mmu_tb;
	import mmu_pkg::*;

	logic                      clk;
	logic                      rst_n_i;
	logic                      if_req_i;
	logic [`MMU_DATA_W-1:0]    if_addr_i;
	logic [`MMU_DATA_W-1:0]    if_rdata_o;
	logic                      if_stall_o;
	logic                      mem_req_i;
	logic                      mem_we_i;
	logic [`MMU_DATA_W/8-1:0]  mem_sel_i;
	logic [`MMU_DATA_W-1:0]    mem_addr_i;
	logic [`MMU_DATA_W-1:0]    mem_wdata_i;
	logic [`MMU_DATA_W-1:0]    mem_rdata_o;
	logic                      mem_stall_o;
	logic                      tlb_we_i;
	logic [`MMU_TLB_IDX_W-1:0] tlb_idx_i;
	logic [19:0]               tlb_vpn_i;
	logic [19:0]               tlb_pfn_i;
	logic                      tlb_v_i;
	logic                      tlb_d_i;
	logic                      exc_valid_o;
	exc_code_e                 exc_code_o;

	logic [7:0]                v_op [`MMU_TB_MAX_VEC];
	logic [3:0]                v_sel [`MMU_TB_MAX_VEC];
	logic [`MMU_DATA_W-1:0]    v_addr [`MMU_TB_MAX_VEC];
	logic [`MMU_DATA_W-1:0]    v_data [`MMU_TB_MAX_VEC];
	logic [`MMU_DATA_W-1:0]    v_exp [`MMU_TB_MAX_VEC];
	exc_code_e                 v_exc [`MMU_TB_MAX_VEC];
	logic [`MMU_DATA_W-1:0]    fill_data [`MMU_TB_FILL_WORDS];
	int                        n_vec;
	int                        errors;
	int                        n_checks;
	int                        errs_before;
	int                        fd;
	int                        rc;
	int                        seed;
	int                        mem_cyc;
	int                        if_cyc;
	string                     line;
	logic [7:0]                op;
	logic [3:0]                sel;
	logic [`MMU_DATA_W-1:0]    addr;
	logic [`MMU_DATA_W-1:0]    data;
	logic [`MMU_DATA_W-1:0]    expv;
	logic [7:0]                excv;
	logic [`MMU_DATA_W-1:0]    fill_addr;
	logic [`MMU_DATA_W-1:0]    mem_data;
	logic [`MMU_DATA_W-1:0]    if_data;
	exc_code_e                 mem_exc;
	exc_code_e                 if_exc;

	mmu_top mmu_top_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.if_req_i(if_req_i), .if_addr_i(if_addr_i),
		.if_rdata_o(if_rdata_o), .if_stall_o(if_stall_o),
		.mem_req_i(mem_req_i), .mem_we_i(mem_we_i), .mem_sel_i(mem_sel_i),
		.mem_addr_i(mem_addr_i), .mem_wdata_i(mem_wdata_i),
		.mem_rdata_o(mem_rdata_o), .mem_stall_o(mem_stall_o),
		.tlb_we_i(tlb_we_i), .tlb_idx_i(tlb_idx_i),
		.tlb_vpn_i(tlb_vpn_i), .tlb_pfn_i(tlb_pfn_i),
		.tlb_v_i(tlb_v_i), .tlb_d_i(tlb_d_i),
		.exc_valid_o(exc_valid_o), .exc_code_o(exc_code_o)
	);

	always #10 clk = ~clk;

	task automatic check_word(input string name, input logic [`MMU_DATA_W-1:0] got,
		input logic [`MMU_DATA_W-1:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("** Error @ %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_exc(input string name, input exc_code_e got, input exc_code_e exp);
		n_checks++;
		if (got !== exp) begin
			$display("** Error @ %0t: %s got %s expected %s", $time, name, got.name(),
				exp.name());
			errors++;
		end
	endtask

	task automatic write_tlb(input logic [3:0] idx, input logic [`MMU_DATA_W-1:0] va,
		input logic [`MMU_DATA_W-1:0] pa, input logic v, input logic d);
		@(posedge clk);
		#2;
		tlb_we_i = 1'b1;
		tlb_idx_i = idx[`MMU_TLB_IDX_W-1:0];
		tlb_vpn_i = va[31:12];
		tlb_pfn_i = pa[31:12];
		tlb_v_i = v;
		tlb_d_i = d;
		@(posedge clk);
		#2;
		tlb_we_i = 1'b0;
	endtask

	// raise req on one or both ports, hold until each stall falls
	task automatic run_access(input logic use_if, input logic use_mem, input logic we,
		input logic [3:0] bsel, input logic [`MMU_DATA_W-1:0] va,
		input logic [`MMU_DATA_W-1:0] wdata);
		logic if_busy;
		logic mem_busy;
		int   cyc;
		if_busy = use_if;
		mem_busy = use_mem;
		cyc = 0;
		mem_exc = EXC_NONE;
		if_exc = EXC_NONE;
		@(posedge clk);
		#2;
		if_req_i = use_if;
		if_addr_i = va;
		mem_req_i = use_mem;
		mem_we_i = we;
		mem_sel_i = bsel;
		mem_addr_i = va;
		mem_wdata_i = wdata;
		while (if_busy || mem_busy) begin
			@(negedge clk); // outputs settled mid cycle
			cyc++;
			if (mem_busy && !mem_stall_o) begin
				mem_data = mem_rdata_o;
				mem_exc = exc_valid_o ? exc_code_o : EXC_NONE;
				mem_cyc = cyc;
				mem_busy = 1'b0;
			end
			if (if_busy && !if_stall_o) begin
				if_data = if_rdata_o;
				if_exc = exc_valid_o ? exc_code_o : EXC_NONE;
				if_cyc = cyc;
				if_busy = 1'b0;
			end
			@(posedge clk);
			#2;
			if (!mem_busy)
				mem_req_i = 1'b0;
			if (!if_busy)
				if_req_i = 1'b0;
		end
	endtask

	initial begin
		wait (n_vec > 0);
		repeat ((n_vec + 2 * `MMU_TB_FILL_WORDS + 4) * `MMU_TB_CYC_PER_OP) @(posedge clk);
		$display("timeout: a request never completed, run stopped at %0t", $time);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n_i = 1'b0;
		if_req_i = 1'b0;
		if_addr_i = '0;
		mem_req_i = 1'b0;
		mem_we_i = 1'b0;
		mem_sel_i = '0;
		mem_addr_i = '0;
		mem_wdata_i = '0;
		tlb_we_i = 1'b0;
		tlb_idx_i = '0;
		tlb_vpn_i = '0;
		tlb_pfn_i = '0;
		tlb_v_i = 1'b0;
		tlb_d_i = 1'b0;
		errors = 0;
		n_checks = 0;
		n_vec = 0;
		seed = 65;
		fd = $fopen("tb/mmu_vectors.txt", "r");
		if (fd == 0) begin
			$display("cannot open the vector file tb/mmu_vectors.txt");
			errors++;
		end else begin
			while (!$feof(fd) && n_vec < `MMU_TB_MAX_VEC) begin
				rc = $fgets(line, fd);
				if (rc == 0)
					break;
				if (line.len() > 0 && line.getc(0) != "#") begin
					rc = $sscanf(line, "%c %h %h %h %h %h", op, sel, addr, data, expv, excv);
					if (rc == 6) begin
						v_op[n_vec] = op;
						v_sel[n_vec] = sel;
						v_addr[n_vec] = addr;
						v_data[n_vec] = data;
						v_exp[n_vec] = expv;
						v_exc[n_vec] = exc_code_e'(excv[2:0]);
						n_vec++;
					end
				end
			end
			$fclose(fd);
			if (n_vec == 0) begin
				$display("no vectors found in tb/mmu_vectors.txt");
				errors++;
			end
		end
		repeat (2) @(posedge clk);
		#2;
		rst_n_i = 1'b1;

		// random words through kseg1, read back through kseg0
		for (int k = 0; k < `MMU_TB_FILL_WORDS; k++) begin
			errs_before = errors;
			fill_addr = 32'hA000_0800 + 32'(4 * k);
			fill_data[k] = $random(seed) ^ fill_addr;
			run_access(1'b0, 1'b1, 1'b1, 4'hf, fill_addr, fill_data[k]);
			check_exc("exc_code_o", mem_exc, EXC_NONE);
			$display("fill store %0d at %h: %s", k, fill_addr,
				(errors == errs_before) ? "ok" : "mismatch");
		end
		for (int k = 0; k < `MMU_TB_FILL_WORDS; k++) begin
			errs_before = errors;
			fill_addr = 32'h8000_0800 + 32'(4 * k);
			run_access(1'b0, 1'b1, 1'b0, 4'hf, fill_addr, '0);
			check_word("mem_rdata_o", mem_data, fill_data[k]);
			check_exc("exc_code_o", mem_exc, EXC_NONE);
			$display("fill load %0d at %h: %s", k, fill_addr,
				(errors == errs_before) ? "ok" : "mismatch");
		end

		for (int i = 0; i < n_vec; i++) begin
			errs_before = errors;
			case (v_op[i])
				"T": write_tlb(v_sel[i], v_addr[i], v_data[i], v_exp[i][0], v_exp[i][1]);
				"F": begin
					run_access(1'b1, 1'b0, 1'b0, 4'hf, v_addr[i], '0);
					if (v_exc[i] == EXC_NONE)
						check_word("if_rdata_o", if_data, v_exp[i]);
					check_exc("exc_code_o", if_exc, v_exc[i]);
				end
				"L": begin
					run_access(1'b0, 1'b1, 1'b0, v_sel[i], v_addr[i], '0);
					if (v_exc[i] == EXC_NONE)
						check_word("mem_rdata_o", mem_data, v_exp[i]);
					check_exc("exc_code_o", mem_exc, v_exc[i]);
				end
				"S": begin
					run_access(1'b0, 1'b1, 1'b1, v_sel[i], v_addr[i], v_data[i]);
					check_exc("exc_code_o", mem_exc, v_exc[i]);
				end
				"B": begin
					run_access(1'b1, 1'b1, 1'b0, v_sel[i], v_addr[i], '0);
					check_word("mem_rdata_o", mem_data, v_exp[i]);
					check_word("if_rdata_o", if_data, v_exp[i]);
					check_exc("exc_code_o", mem_exc, v_exc[i]);
					check_exc("exc_code_o", if_exc, v_exc[i]);
					n_checks++;
					if (mem_cyc > if_cyc) begin
						$display("data port finished after the fetch port in vector %0d", i);
						errors++;
					end
				end
				default: begin
					$display("unknown operation in vector %0d", i);
					errors++;
				end
			endcase
			$display("vector %0d %c %h: %s", i, v_op[i], v_addr[i],
				(errors == errs_before) ? "ok" : "mismatch");
		end

		if (mmu_top_inst.chk_inst.fail_count != 0) begin
			$display("%0d assertion failures in the bound checker",
				mmu_top_inst.chk_inst.fail_count);
			errors += mmu_top_inst.chk_inst.fail_count;
		end

		$display("%0d tests, %0d checks, %0d errors", n_vec + 2 * `MMU_TB_FILL_WORDS,
			n_checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/mmu_chk.sv
`default_nettype none
`timescale 1ns/1ps

module mmu_chk (
	input wire clk,
	input wire rst_n_i,
	input wire if_req_i,
	input wire if_stall_i,
	input wire mem_req_i,
	input wire mem_stall_i,
	input wire exc_valid_i,
	input wire awvalid_i,
	input wire awready_i,
	input wire wvalid_i,
	input wire wready_i,
	input wire bvalid_i,
	input wire arvalid_i,
	input wire arready_i,
	input wire rvalid_i
);
	int fail_count = 0;

	// a new request is never done in the cycle it is raised
	a_if_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(if_req_i) |-> if_stall_i) else begin
		fail_count++;
		$error("fetch request done in the cycle it was raised");
	end
	a_mem_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		$rose(mem_req_i) |-> mem_stall_i) else begin
		fail_count++;
		$error("data request done in the cycle it was raised");
	end

	// fault flag only while some port is completing
	a_exc_done: assert property (@(posedge clk) disable iff (!rst_n_i)
		exc_valid_i |-> ((mem_req_i && !mem_stall_i) || (if_req_i && !if_stall_i)))
		else begin
		fail_count++;
		$error("exc_valid outside a completion cycle");
	end

	a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(awvalid_i && !awready_i) |=> awvalid_i) else begin
		fail_count++;
		$error("awvalid dropped early");
	end
	a_w_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(wvalid_i && !wready_i) |=> wvalid_i) else begin
		fail_count++;
		$error("wvalid dropped early");
	end
	a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		(arvalid_i && !arready_i) |=> arvalid_i) else begin
		fail_count++;
		$error("arvalid dropped early");
	end

	// response one cycle after the address handshake
	a_b_next: assert property (@(posedge clk) disable iff (!rst_n_i)
		(awvalid_i && awready_i) |=> bvalid_i) else begin
		fail_count++;
		$error("bvalid missing after the write handshake");
	end
	a_r_next: assert property (@(posedge clk) disable iff (!rst_n_i)
		(arvalid_i && arready_i) |=> rvalid_i) else begin
		fail_count++;
		$error("rvalid missing after the read handshake");
	end

endmodule

bind mmu_top mmu_chk chk_inst (
	.clk(clk), .rst_n_i(rst_n_i),
	.if_req_i(if_req_i), .if_stall_i(if_stall_o),
	.mem_req_i(mem_req_i), .mem_stall_i(mem_stall_o),
	.exc_valid_i(exc_valid_o),
	.awvalid_i(awvalid), .awready_i(awready),
	.wvalid_i(wvalid), .wready_i(wready),
	.bvalid_i(bvalid),
	.arvalid_i(arvalid), .arready_i(arready),
	.rvalid_i(rvalid)
);

`default_nettype wire

//--- design/mmu_top.sv
`default_nettype none
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mmu_top (
	input  wire                       clk,
	input  wire                       rst_n_i,
	input  wire                       if_req_i,
	input  wire  [`MMU_DATA_W-1:0]    if_addr_i,
	output logic [`MMU_DATA_W-1:0]    if_rdata_o,
	output logic                      if_stall_o,
	input  wire                       mem_req_i,
	input  wire                       mem_we_i,
	input  wire  [`MMU_DATA_W/8-1:0]  mem_sel_i,
	input  wire  [`MMU_DATA_W-1:0]    mem_addr_i,
	input  wire  [`MMU_DATA_W-1:0]    mem_wdata_i,
	output logic [`MMU_DATA_W-1:0]    mem_rdata_o,
	output logic                      mem_stall_o,
	input  wire                       tlb_we_i,
	input  wire  [`MMU_TLB_IDX_W-1:0] tlb_idx_i,
	input  wire  [19:0]               tlb_vpn_i,
	input  wire  [19:0]               tlb_pfn_i,
	input  wire                       tlb_v_i,
	input  wire                       tlb_d_i,
	output logic                      exc_valid_o,
	output mmu_pkg::exc_code_e        exc_code_o
);
	import mmu_pkg::*;

	logic [`MMU_DATA_W-1:0]   xl_vaddr, xl_paddr;
	logic                     xl_store;
	exc_code_e                xl_exc;
	logic                     cmd_valid, cmd_we, cmd_done, cmd_err;
	logic [`MMU_DATA_W-1:0]   cmd_addr, cmd_wdata, cmd_rdata;
	logic                     awvalid, awready, wvalid, wready, bvalid, bready;
	logic                     arvalid, arready, rvalid, rready;
	logic [`MMU_DATA_W-1:0]   awaddr, wdata, araddr, rdata;
	logic [`MMU_DATA_W/8-1:0] wstrb;
	logic [1:0]               bresp, rresp;

	mem_port_arbiter arb_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.if_req_i(if_req_i), .if_addr_i(if_addr_i),
		.if_rdata_o(if_rdata_o), .if_stall_o(if_stall_o),
		.mem_req_i(mem_req_i), .mem_we_i(mem_we_i), .mem_sel_i(mem_sel_i),
		.mem_addr_i(mem_addr_i), .mem_wdata_i(mem_wdata_i),
		.mem_rdata_o(mem_rdata_o), .mem_stall_o(mem_stall_o),
		.xl_vaddr_o(xl_vaddr), .xl_store_o(xl_store),
		.xl_paddr_i(xl_paddr), .xl_exc_i(xl_exc),
		.cmd_valid_o(cmd_valid), .cmd_we_o(cmd_we),
		.cmd_addr_o(cmd_addr), .cmd_wdata_o(cmd_wdata),
		.cmd_done_i(cmd_done), .cmd_rdata_i(cmd_rdata), .cmd_err_i(cmd_err),
		.exc_valid_o(exc_valid_o), .exc_code_o(exc_code_o)
	);

	addr_xlate #(
		.n_entries(`MMU_TLB_ENTRIES)
	) xlate_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.vaddr_i(xl_vaddr), .store_i(xl_store),
		.paddr_o(xl_paddr), .exc_o(xl_exc),
		.tlb_we_i(tlb_we_i), .tlb_idx_i(tlb_idx_i),
		.tlb_vpn_i(tlb_vpn_i), .tlb_pfn_i(tlb_pfn_i),
		.tlb_v_i(tlb_v_i), .tlb_d_i(tlb_d_i)
	);

	axil_master master_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.cmd_valid_i(cmd_valid), .cmd_we_i(cmd_we),
		.cmd_addr_i(cmd_addr), .cmd_wdata_i(cmd_wdata),
		.cmd_done_o(cmd_done), .cmd_rdata_o(cmd_rdata), .cmd_err_o(cmd_err),
		.m_awvalid_o(awvalid), .m_awready_i(awready), .m_awaddr_o(awaddr),
		.m_wvalid_o(wvalid), .m_wready_i(wready),
		.m_wdata_o(wdata), .m_wstrb_o(wstrb),
		.m_bvalid_i(bvalid), .m_bready_o(bready), .m_bresp_i(bresp),
		.m_arvalid_o(arvalid), .m_arready_i(arready), .m_araddr_o(araddr),
		.m_rvalid_i(rvalid), .m_rready_o(rready),
		.m_rdata_i(rdata), .m_rresp_i(rresp)
	);

	axil_ram ram_inst (
		.clk(clk), .rst_n_i(rst_n_i),
		.s_awvalid_i(awvalid), .s_awready_o(awready), .s_awaddr_i(awaddr),
		.s_wvalid_i(wvalid), .s_wready_o(wready),
		.s_wdata_i(wdata), .s_wstrb_i(wstrb),
		.s_bvalid_o(bvalid), .s_bready_i(bready), .s_bresp_o(bresp),
		.s_arvalid_i(arvalid), .s_arready_o(arready), .s_araddr_i(araddr),
		.s_rvalid_o(rvalid), .s_rready_i(rready),
		.s_rdata_o(rdata), .s_rresp_o(rresp)
	);

endmodule

`default_nettype wire

//--- design/axil_ram.sv
`default_nettype none
`timescale 1ns/1ps
`include "mmu_consts.svh"

module axil_ram (
	input  wire                       clk,
	input  wire                       rst_n_i,
	input  wire                       s_awvalid_i,
	output logic                      s_awready_o,
	input  wire  [`MMU_DATA_W-1:0]    s_awaddr_i,
	input  wire                       s_wvalid_i,
	output logic                      s_wready_o,
	input  wire  [`MMU_DATA_W-1:0]    s_wdata_i,
	input  wire  [`MMU_DATA_W/8-1:0]  s_wstrb_i,
	output logic                      s_bvalid_o,
	input  wire                       s_bready_i,
	output logic [1:0]                s_bresp_o,
	input  wire                       s_arvalid_i,
	output logic                      s_arready_o,
	input  wire  [`MMU_DATA_W-1:0]    s_araddr_i,
	output logic                      s_rvalid_o,
	input  wire                       s_rready_i,
	output logic [`MMU_DATA_W-1:0]    s_rdata_o,
	output logic [1:0]                s_rresp_o
);
	localparam int idx_w = $clog2(`MMU_RAM_WORDS);
	localparam logic [`MMU_DATA_W-3:0] depth = `MMU_RAM_WORDS;

	logic [`MMU_DATA_W-1:0] mem [`MMU_RAM_WORDS];
	logic                   wr_fire;
	logic                   rd_fire;
	logic                   wr_hit;
	logic                   rd_hit;

	assign s_awready_o = s_awvalid_i && s_wvalid_i && !s_bvalid_o; // need both halves
	assign s_wready_o = s_awready_o;
	assign s_arready_o = !s_rvalid_o;

	assign wr_fire = s_awvalid_i && s_awready_o;
	assign rd_fire = s_arvalid_i && s_arready_o;
	assign wr_hit = s_awaddr_i[`MMU_DATA_W-1:2] < depth;
	assign rd_hit = s_araddr_i[`MMU_DATA_W-1:2] < depth;

	always_ff @(posedge clk) begin
		if (wr_fire && wr_hit && (&s_wstrb_i)) begin // no byte lanes in this ram
			mem[s_awaddr_i[idx_w+1:2]] <= s_wdata_i;
		end
		if (wr_fire) begin
			s_bresp_o <= wr_hit ? `MMU_RESP_OKAY : `MMU_RESP_DECERR;
		end
		if (rd_fire) begin
			s_rdata_o <= rd_hit ? mem[s_araddr_i[idx_w+1:2]] : '0;
			s_rresp_o <= rd_hit ? `MMU_RESP_OKAY : `MMU_RESP_DECERR;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			s_bvalid_o <= 1'b0;
			s_rvalid_o <= 1'b0;
		end else begin
			if (wr_fire) begin
				s_bvalid_o <= 1'b1;
			end else if (s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
			if (rd_fire) begin
				s_rvalid_o <= 1'b1;
			end else if (s_rready_i) begin
				s_rvalid_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/axil_master.sv
`default_nettype none
`timescale 1ns/1ps
`include "mmu_consts.svh"

module axil_master (
	input  wire                       clk,
	input  wire                       rst_n_i,
	input  wire                       cmd_valid_i,
	input  wire                       cmd_we_i,
	input  wire  [`MMU_DATA_W-1:0]    cmd_addr_i,
	input  wire  [`MMU_DATA_W-1:0]    cmd_wdata_i,
	output logic                      cmd_done_o,
	output logic [`MMU_DATA_W-1:0]    cmd_rdata_o,
	output logic                      cmd_err_o,
	output logic                      m_awvalid_o,
	input  wire                       m_awready_i,
	output logic [`MMU_DATA_W-1:0]    m_awaddr_o,
	output logic                      m_wvalid_o,
	input  wire                       m_wready_i,
	output logic [`MMU_DATA_W-1:0]    m_wdata_o,
	output logic [`MMU_DATA_W/8-1:0]  m_wstrb_o,
	input  wire                       m_bvalid_i,
	output logic                      m_bready_o,
	input  wire  [1:0]                m_bresp_i,
	output logic                      m_arvalid_o,
	input  wire                       m_arready_i,
	output logic [`MMU_DATA_W-1:0]    m_araddr_o,
	input  wire                       m_rvalid_i,
	output logic                      m_rready_o,
	input  wire  [`MMU_DATA_W-1:0]    m_rdata_i,
	input  wire  [1:0]                m_rresp_i
);
	logic                   busy_q;
	logic                   we_q;
	logic [`MMU_DATA_W-1:0] addr_q;
	logic [`MMU_DATA_W-1:0] data_q;
	logic [1:0]             resp;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			we_q <= 1'b0;
			m_awvalid_o <= 1'b0;
			m_wvalid_o <= 1'b0;
			m_arvalid_o <= 1'b0;
		end else if (!busy_q) begin
			if (cmd_valid_i) begin
				busy_q <= 1'b1;
				we_q <= cmd_we_i;
				m_awvalid_o <= cmd_we_i; // aw and w go out together
				m_wvalid_o <= cmd_we_i;
				m_arvalid_o <= !cmd_we_i;
			end
		end else begin
			if (m_awready_i) begin
				m_awvalid_o <= 1'b0;
			end
			if (m_wready_i) begin
				m_wvalid_o <= 1'b0;
			end
			if (m_arready_i) begin
				m_arvalid_o <= 1'b0;
			end
			if (cmd_done_o) begin
				busy_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy_q && cmd_valid_i) begin
			addr_q <= cmd_addr_i;
			data_q <= cmd_wdata_i;
		end
	end

	assign m_awaddr_o = addr_q;
	assign m_araddr_o = addr_q;
	assign m_wdata_o = data_q;
	assign m_wstrb_o = '1; // always whole words
	assign m_bready_o = 1'b1;
	assign m_rready_o = 1'b1;

	assign resp = we_q ? m_bresp_i : m_rresp_i;
	assign cmd_done_o = busy_q &&
		(we_q ? (m_bvalid_i && m_bready_o) : (m_rvalid_i && m_rready_o));
	assign cmd_rdata_o = m_rdata_i;
	assign cmd_err_o = (resp == `MMU_RESP_DECERR);

endmodule

`default_nettype wire

//--- design/mem_port_arbiter.sv
`default_nettype none
`timescale 1ns/1ps
`include "mmu_consts.svh"

module mem_port_arbiter (
	input  wire                         clk,
	input  wire                         rst_n_i,
	input  wire                         if_req_i,
	input  wire  [`MMU_DATA_W-1:0]      if_addr_i,
	output logic [`MMU_DATA_W-1:0]      if_rdata_o,
	output logic                        if_stall_o,
	input  wire                         mem_req_i,
	input  wire                         mem_we_i,
	input  wire  [`MMU_DATA_W/8-1:0]    mem_sel_i,
	input  wire  [`MMU_DATA_W-1:0]      mem_addr_i,
	input  wire  [`MMU_DATA_W-1:0]      mem_wdata_i,
	output logic [`MMU_DATA_W-1:0]      mem_rdata_o,
	output logic                        mem_stall_o,
	output logic [`MMU_DATA_W-1:0]      xl_vaddr_o,
	output logic                        xl_store_o,
	input  wire  [`MMU_DATA_W-1:0]      xl_paddr_i,
	input  wire  mmu_pkg::exc_code_e    xl_exc_i,
	output logic                        cmd_valid_o,
	output logic                        cmd_we_o,
	output logic [`MMU_DATA_W-1:0]      cmd_addr_o,
	output logic [`MMU_DATA_W-1:0]      cmd_wdata_o,
	input  wire                         cmd_done_i,
	input  wire  [`MMU_DATA_W-1:0]      cmd_rdata_i,
	input  wire                         cmd_err_i,
	output logic                        exc_valid_o,
	output mmu_pkg::exc_code_e          exc_code_o
);
	import mmu_pkg::*;

	localparam logic [2:0] s_idle      = 3'd0;
	localparam logic [2:0] s_mem_read  = 3'd1;
	localparam logic [2:0] s_mem_write = 3'd2;
	localparam logic [2:0] s_fetch     = 3'd3;
	localparam logic [2:0] s_complete  = 3'd4;

	logic [2:0]             state_q;
	logic                   sel_mem_q; // data port is being served
	exc_code_e              exc_q;
	logic [`MMU_DATA_W-1:0] paddr_q;
	logic [`MMU_DATA_W-1:0] wdata_q;
	logic [`MMU_DATA_W-1:0] rdata_q;
	logic [`MMU_DATA_W-1:0] merged;
	logic                   full_word;

	assign full_word = &mem_sel_i;

	// data port wins the translator when both ask
	assign xl_vaddr_o = mem_req_i ? mem_addr_i : if_addr_i;
	assign xl_store_o = mem_req_i && mem_we_i;

	// selected bytes from the store, the rest from memory
	always_comb begin
		merged = cmd_rdata_i;
		for (int b = 0; b < `MMU_DATA_W/8; b++) begin
			if (mem_sel_i[b]) begin
				merged[8*b +: 8] = mem_wdata_i[8*b +: 8];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= s_idle;
			sel_mem_q <= 1'b0;
			exc_q <= EXC_NONE;
		end else begin
			case (state_q)
				s_idle: begin
					if (mem_req_i || if_req_i) begin
						sel_mem_q <= mem_req_i;
						exc_q <= xl_exc_i;
						if (xl_exc_i != EXC_NONE) begin
							state_q <= s_complete; // fault, no bus access
						end else if (!mem_req_i) begin
							state_q <= s_fetch;
						end else if (mem_we_i && full_word) begin
							state_q <= s_mem_write;
						end else begin
							state_q <= s_mem_read; // load, or first half of rmw
						end
					end
				end
				s_mem_read: begin
					if (cmd_done_i) begin
						if (cmd_err_i) begin
							exc_q <= EXC_BUS;
							state_q <= s_complete;
						end else if (mem_we_i) begin
							state_q <= s_mem_write;
						end else begin
							state_q <= s_complete;
						end
					end
				end
				s_mem_write, s_fetch: begin
					if (cmd_done_i) begin
						if (cmd_err_i) begin
							exc_q <= EXC_BUS;
						end
						state_q <= s_complete;
					end
				end
				s_complete: begin
					state_q <= s_idle;
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == s_idle) begin
			paddr_q <= xl_paddr_i;
			wdata_q <= mem_wdata_i;
		end
		if (cmd_done_i && (state_q == s_mem_read || state_q == s_fetch)) begin
			rdata_q <= cmd_rdata_i;
		end
		if (cmd_done_i && state_q == s_mem_read) begin
			wdata_q <= merged;
		end
	end

	assign cmd_valid_o = (state_q == s_mem_read) || (state_q == s_mem_write) ||
		(state_q == s_fetch);
	assign cmd_we_o = (state_q == s_mem_write);
	assign cmd_addr_o = paddr_q;
	assign cmd_wdata_o = wdata_q;

	assign mem_stall_o = mem_req_i && !(state_q == s_complete && sel_mem_q);
	assign if_stall_o = if_req_i && !(state_q == s_complete && !sel_mem_q);
	assign mem_rdata_o = rdata_q;
	assign if_rdata_o = rdata_q;

	assign exc_valid_o = (state_q == s_complete) && (exc_q != EXC_NONE);
	assign exc_code_o = exc_q;

endmodule

`default_nettype wire

//--- design/addr_xlate.sv
`default_nettype none
`timescale 1ns/1ps
`include "mmu_consts.svh"

module addr_xlate #(
	parameter int n_entries = `MMU_TLB_ENTRIES
) (
	input  wire                       clk,
	input  wire                       rst_n_i,
	input  wire  [`MMU_DATA_W-1:0]    vaddr_i,
	input  wire                       store_i,
	output logic [`MMU_DATA_W-1:0]    paddr_o,
	output mmu_pkg::exc_code_e        exc_o,
	input  wire                       tlb_we_i,
	input  wire  [`MMU_TLB_IDX_W-1:0] tlb_idx_i,
	input  wire  [19:0]               tlb_vpn_i,
	input  wire  [19:0]               tlb_pfn_i,
	input  wire                       tlb_v_i,
	input  wire                       tlb_d_i
);
	import mmu_pkg::*;

	localparam logic [`MMU_DATA_W-1:0] kseg0_base = `MMU_KSEG0_BASE;
	localparam logic [`MMU_DATA_W-1:0] kseg1_base = `MMU_KSEG1_BASE;

	vaddr_u              va;
	logic [19:0]         tlb_vpn [n_entries];
	logic [19:0]         tlb_pfn [n_entries];
	logic [n_entries-1:0] tlb_v;
	logic [n_entries-1:0] tlb_d;
	logic                direct;
	logic                hit;
	logic                hit_d;
	logic [19:0]         hit_pfn;

	assign va = vaddr_i;
	assign direct = (va.seg.segment == kseg0_base[`MMU_DATA_W-1 -: 3]) ||
		(va.seg.segment == kseg1_base[`MMU_DATA_W-1 -: 3]);

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			tlb_v <= '0;
		end else if (tlb_we_i) begin
			tlb_v[tlb_idx_i] <= tlb_v_i;
		end
	end

	always_ff @(posedge clk) begin
		if (tlb_we_i) begin
			tlb_vpn[tlb_idx_i] <= tlb_vpn_i;
			tlb_pfn[tlb_idx_i] <= tlb_pfn_i;
			tlb_d[tlb_idx_i] <= tlb_d_i;
		end
	end

	always_comb begin
		hit = 1'b0;
		hit_d = 1'b0;
		hit_pfn = '0;
		for (int i = 0; i < n_entries; i++) begin
			if (!hit && tlb_v[i] && (tlb_vpn[i] == va.page.vpn)) begin // lowest index wins
				hit = 1'b1;
				hit_d = tlb_d[i];
				hit_pfn = tlb_pfn[i];
			end
		end
	end

	always_comb begin
		paddr_o = {3'b000, va.seg.offset}; // kseg0/kseg1 strip segment
		exc_o = EXC_NONE;
		if (!direct) begin
			paddr_o = {hit_pfn, va.page.poff};
			if (!hit) begin
				exc_o = store_i ? EXC_TLBS : EXC_TLBL;
			end else if (store_i && !hit_d) begin
				exc_o = EXC_TLBM;
			end
		end
	end

endmodule

`default_nettype wire

//--- design/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	// one virtual address word, decoded by segment or by page
	typedef union packed {
		struct packed {
			logic [2:0]  segment; // top bits pick kuseg/kseg0/kseg1/...
			logic [28:0] offset;
		} seg;
		struct packed {
			logic [19:0] vpn;
			logic [11:0] poff;
		} page;
	} vaddr_u;

	typedef enum logic [2:0] {
		EXC_NONE = 3'd0,
		EXC_TLBL = 3'd1, // tlb miss on load or fetch
		EXC_TLBS = 3'd2, // tlb miss on store
		EXC_TLBM = 3'd3, // store to clean page
		EXC_BUS  = 3'd4
	} exc_code_e;

endpackage

`default_nettype wire

//--- include/mmu_consts.svh
`ifndef MMU_CONSTS_SVH
`define MMU_CONSTS_SVH

// word and memory geometry
`define MMU_DATA_W       32
`define MMU_RAM_WORDS    1024

// tlb size
`define MMU_TLB_ENTRIES  4
`define MMU_TLB_IDX_W    2

// unmapped kernel segments
`define MMU_KSEG0_BASE   32'h8000_0000
`define MMU_KSEG1_BASE   32'hA000_0000

// axi response codes
`define MMU_RESP_OKAY    2'b00
`define MMU_RESP_DECERR  2'b11

`endif
